//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_ternary_mac
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# exit status of the simulation is the pass or fail result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- common/ternary_pkg.sv
package ternary_pkg;

    // five ternary weights fit in one byte since 3^5 = 243 <= 256
    localparam int num_rows = 5;

    // weight byte, activation byte and result byte all share this width
    localparam int data_width = 8;

    // 17 bits holds 512 worst-case accumulations of -128 without wrap
    localparam int acc_width_default = 17;

    // lowest accumulator bit that lands on the output byte
    localparam int out_lsb = 8;

    // codes 0..242 are real packings, 243..255 are spare
    localparam int num_codes = 243;

    // encoding matches the base-3 digit value, so a digit maps straight across
    typedef enum logic [1:0] {
        MAC_HOLD = 2'd0,
        MAC_ADD  = 2'd1,
        MAC_SUB  = 2'd2
    } mac_op_e;

    // one operation per accumulator row, index is the row number
    typedef mac_op_e [num_rows-1:0] mac_op_vec_t;

endpackage

//--- design/mac_array/mac_array.sv
`timescale 1ns/1ps

module mac_array #(
    parameter int acc_width = ternary_pkg::acc_width_default
) (
    input  logic                                            clk,
    input  logic                                            reset,
    input  ternary_pkg::mac_op_vec_t                        ops_cur,
    input  logic signed [ternary_pkg::data_width-1:0]       act_cur,
    input  logic                                            run,
    output logic [ternary_pkg::num_rows-1:0][acc_width-1:0] acc_next
);

    localparam int ext_bits = acc_width - ternary_pkg::data_width;

    // row accumulators, two's complement
    logic [ternary_pkg::num_rows-1:0][acc_width-1:0] acc;

    // activation widened to accumulator width
    logic [acc_width-1:0] act_ext;

    // replicate the sign bit so negative activations stay negative
    assign act_ext = {{ext_bits{act_cur[ternary_pkg::data_width-1]}}, act_cur};

    // one adder/subtractor per row, selected by the trit
    always_comb begin
        for (int r = 0; r < ternary_pkg::num_rows; r++) begin
            case (ops_cur[r])
                ternary_pkg::MAC_ADD: acc_next[r] = acc[r] + act_ext;
                ternary_pkg::MAC_SUB: acc_next[r] = acc[r] - act_ext;
                // zero weight leaves the row alone
                default:              acc_next[r] = acc[r];
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // readout edge: the queue grabs acc_next, rows start the next batch
        if (reset || !run) begin
            acc <= '0;
        end else begin
            acc <= acc_next;
        end
    end

    // every row starts a new batch from zero right after a readout
    a_clear_on_read: assert property (@(posedge clk)
        !run |=> (acc == '0));

endmodule

//--- design/mac_array/readout_queue.sv
`timescale 1ns/1ps

module readout_queue #(
    parameter int acc_width = ternary_pkg::acc_width_default
) (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic [ternary_pkg::num_rows-1:0][acc_width-1:0] acc_next,
    input  logic                                            run,
    output logic [ternary_pkg::data_width-1:0]              result_out
);

    // snapshot of the rows, entry 0 faces the output pins
    logic [ternary_pkg::num_rows-1:0][acc_width-1:0] entry;

    always_ff @(posedge clk) begin
        if (reset) begin
            entry <= '0;
        end else if (!run) begin
            // capture includes the operand applied at this same edge
            entry <= acc_next;
        end else begin
            // shift toward entry 0, last entry keeps its value
            for (int n = 0; n < ternary_pkg::num_rows - 1; n++) begin
                entry[n] <= entry[n+1];
            end
        end
    end

    // middle byte of the accumulator, i.e. the sum divided by 256
    assign result_out = entry[0][ternary_pkg::out_lsb +: ternary_pkg::data_width];

    // row 0 of the mac array must show up first, one cycle after the load
    a_load_row0: assert property (@(posedge clk) disable iff (reset)
        !run |=> (entry[0] == $past(acc_next[0])));

endmodule

//--- design/operand_stage.sv
`timescale 1ns/1ps

module operand_stage (
    input  logic                                      clk,
    input  logic                                      reset,
    input  ternary_pkg::mac_op_vec_t                  ops_raw,
    input  logic signed [ternary_pkg::data_width-1:0] activation_in,
    output ternary_pkg::mac_op_vec_t                  ops_cur,
    output logic signed [ternary_pkg::data_width-1:0] act_cur
);

    // first stage, captures the pins
    ternary_pkg::mac_op_vec_t                  ops_next;
    logic signed [ternary_pkg::data_width-1:0] act_next;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ternary_pkg::num_rows; i++) begin
                ops_next[i] <= ternary_pkg::MAC_HOLD;
                ops_cur[i]  <= ternary_pkg::MAC_HOLD;
            end
            act_next <= '0;
            act_cur  <= '0;
        end else begin
            ops_next <= ops_raw;
            act_next <= activation_in;
            // second stage feeds the accumulators
            ops_cur  <= ops_next;
            act_cur  <= act_next;
        end
    end

    // spare digit value 3 must never reach the accumulators
    for (genvar i = 0; i < ternary_pkg::num_rows; i++) begin : g_op_chk
        a_op_legal: assert property (@(posedge clk) disable iff (reset)
            ops_cur[i] inside {ternary_pkg::MAC_HOLD, ternary_pkg::MAC_ADD,
                               ternary_pkg::MAC_SUB});
    end

endmodule

//--- design/ternary_mac_top.sv
`timescale 1ns/1ps

module ternary_mac_top #(
    parameter int acc_width = ternary_pkg::acc_width_default
) (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [ternary_pkg::data_width-1:0]     weights_in,
    input  logic signed [ternary_pkg::data_width-1:0] activation_in,
    input  logic                                   run,
    output logic [ternary_pkg::data_width-1:0]     result_out
);

    // decoded per-row operations, same cycle as weights_in
    ternary_pkg::mac_op_vec_t ops_raw;

    // operands after the two register stages
    ternary_pkg::mac_op_vec_t                 ops_cur;
    logic signed [ternary_pkg::data_width-1:0] act_cur;

    // next accumulator values, also the snapshot source for readout
    logic [ternary_pkg::num_rows-1:0][acc_width-1:0] acc_next;

    trit_unpacker u_unpacker (
        .weights_in (weights_in),
        .ops_raw    (ops_raw)
    );

    // two bytes in flight between the pins and the accumulators
    operand_stage u_operands (
        .clk           (clk),
        .reset         (reset),
        .ops_raw       (ops_raw),
        .activation_in (activation_in),
        .ops_cur       (ops_cur),
        .act_cur       (act_cur)
    );

    // run low clears the rows at the same edge the queue snapshots them
    mac_array #(.acc_width(acc_width)) u_mac (
        .clk      (clk),
        .reset    (reset),
        .ops_cur  (ops_cur),
        .act_cur  (act_cur),
        .run      (run),
        .acc_next (acc_next)
    );

    readout_queue #(.acc_width(acc_width)) u_queue (
        .clk        (clk),
        .reset      (reset),
        .acc_next   (acc_next),
        .run        (run),
        .result_out (result_out)
    );

endmodule

//--- design/trit_unpacker.sv
`timescale 1ns/1ps

module trit_unpacker (
    input  logic [ternary_pkg::data_width-1:0] weights_in,
    output ternary_pkg::mac_op_vec_t           ops_raw
);

    // packing convention: base-3 digit k (lsd first) drives row num_rows-1-k
    function automatic int row_of_digit(input int k);
        return ternary_pkg::num_rows - 1 - k;
    endfunction

    // quotient left after peeling off the lower digits
    logic [ternary_pkg::data_width-1:0] rem;

    // current digit, 0 hold / 1 add / 2 subtract
    logic [1:0] digit;

    // spare codes above the last valid packing
    logic spare_code;

    assign spare_code = (weights_in >= ternary_pkg::num_codes);

    always_comb begin
        rem   = weights_in;
        digit = 2'd0;
        for (int k = 0; k < ternary_pkg::num_rows; k++) begin
            // successive division by three yields digits lsd first
            digit = 2'(rem % 3);
            rem   = rem / 3;
            // spare codes behave as +1 on every row
            if (spare_code) begin
                ops_raw[row_of_digit(k)] = ternary_pkg::MAC_ADD;
            end else begin
                ops_raw[row_of_digit(k)] = ternary_pkg::mac_op_e'(digit);
            end
        end
    end

endmodule

//--- verif/tb_ternary_mac.sv
`timescale 1ns/1ps

module tb_ternary_mac;

    localparam int acc_width    = ternary_pkg::acc_width_default;
    localparam int clk_period   = 10;
    localparam int reset_cycles = 8;

    // one table row and the result_out expected after the edge that samples it
    typedef struct {
        logic [7:0] weights;
        logic [7:0] activation;
        logic       run;
        logic [7:0] expected;
    } stim_t;

    logic              clk = 1'b0;
    logic              reset;
    logic [7:0]        weights_in;
    logic signed [7:0] activation_in;
    logic              run;
    logic [7:0]        result_out;

    stim_t stim[$];
    logic  table_ready = 1'b0;
    int    seed = 32'hc1d19c8a;

    // reference model state that starts cleared like the DUT after reset
    logic [acc_width-1:0] m_acc[ternary_pkg::num_rows];
    logic [acc_width-1:0] m_q[ternary_pkg::num_rows];
    logic [7:0]           stage1_w;
    logic [7:0]           stage2_w;
    logic signed [7:0]    stage1_a;
    logic signed [7:0]    stage2_a;

    ternary_mac_top #(.acc_width(acc_width)) dut0 (
        .clk           (clk),
        .reset         (reset),
        .weights_in    (weights_in),
        .activation_in (activation_in),
        .run           (run),
        .result_out    (result_out)
    );

    always #(clk_period / 2) clk = ~clk;

    // weight of row r as -1, 0 or +1 taken from base-3 digit 4-r
    function automatic int trit_of(input logic [7:0] code, input int row);
        int value;
        int digit;
        value = int'(code);
        if (value >= ternary_pkg::num_codes) begin
            return 1;
        end
        for (int k = 0; k < ternary_pkg::num_rows - 1 - row; k++) begin
            value = value / 3;
        end
        digit = value % 3;
        return (digit == 2) ? -1 : digit;
    endfunction

    task automatic push_entry(input int code, input int act, input logic run_lvl);
        stim_t e;
        e.weights    = 8'(code);
        e.activation = 8'(act);
        e.run        = run_lvl;
        e.expected   = 8'h00;
        stim.push_back(e);
    endtask

    task automatic repeat_word(input int code, input int act, input int count);
        for (int i = 0; i < count; i++) begin
            push_entry(code, act, 1'b1);
        end
    endtask

    // two idle bytes drain the operand pipe before the readout walks all rows
    task automatic flush_and_read();
        repeat_word(0, 0, 2);
        push_entry(0, 0, 1'b0);
        repeat_word(0, 0, 6);
    endtask

    // one clock edge of the model with the inputs that edge samples
    task automatic model_step(input logic [7:0] w, input logic [7:0] a,
                              input logic run_lvl, output logic [7:0] out_byte);
        logic [acc_width-1:0] sum[ternary_pkg::num_rows];
        int act_val;
        act_val = int'(stage2_a);
        for (int r = 0; r < ternary_pkg::num_rows; r++) begin
            sum[r] = m_acc[r] + acc_width'(trit_of(stage2_w, r) * act_val);
        end
        if (!run_lvl) begin
            // readout snapshots the sums and starts a fresh batch
            for (int r = 0; r < ternary_pkg::num_rows; r++) begin
                m_q[r]   = sum[r];
                m_acc[r] = '0;
            end
        end else begin
            for (int r = 0; r < ternary_pkg::num_rows - 1; r++) begin
                m_q[r] = m_q[r+1];
            end
            for (int r = 0; r < ternary_pkg::num_rows; r++) begin
                m_acc[r] = sum[r];
            end
        end
        // two register stages between the pins and the rows
        stage2_w = stage1_w;
        stage2_a = stage1_a;
        stage1_w = w;
        stage1_a = a;
        out_byte = m_q[0][ternary_pkg::out_lsb +: ternary_pkg::data_width];
    endtask

    task automatic fill_expected();
        logic [7:0] out_byte;
        for (int r = 0; r < ternary_pkg::num_rows; r++) begin
            m_acc[r] = '0;
            m_q[r]   = '0;
        end
        stage1_w = 8'h00;
        stage2_w = 8'h00;
        stage1_a = 8'sh00;
        stage2_a = 8'sh00;
        for (int i = 0; i < stim.size(); i++) begin
            model_step(stim[i].weights, stim[i].activation, stim[i].run, out_byte);
            stim[i].expected = out_byte;
        end
    endtask

    task automatic build_table();
        int single_codes[10] = '{1, 3, 9, 27, 81, 2, 6, 18, 54, 162};
        int rnd;
        // idle after reset keeps the output at 0
        repeat_word(0, 0, 6);
        // one nonzero weight per code with +1 then -1 on each row
        foreach (single_codes[i]) begin
            repeat_word(single_codes[i], 100, 4);
            flush_and_read();
        end
        // all rows subtract a negative activation
        repeat_word(242, -128, 8);
        flush_and_read();
        // all rows add a negative activation so the middle byte wraps to fd
        repeat_word(121, -128, 6);
        flush_and_read();
        // mixed row signs
        repeat_word(100, 127, 5);
        repeat_word(200, -77, 3);
        flush_and_read();
        // spare codes act as five +1 weights
        for (int c = 243; c < 256; c++) begin
            push_entry(c, 100, 1'b1);
        end
        // code 0 must not move any row
        repeat_word(0, 127, 4);
        flush_and_read();
        // back-to-back batches where the bytes at m-1 and m go to batch two
        // row 0 sits exactly on 256, so one byte too few shows as 00
        repeat_word(81, 64, 4);
        // a single stray byte on row 4 of batch one would show as ff
        push_entry(1, -128, 1'b1);
        push_entry(1, -128, 1'b0);
        repeat_word(1, -128, 2);
        repeat_word(0, 0, 4);
        flush_and_read();
        // random bytes with rare readout pulses
        for (int i = 0; i < 200; i++) begin
            rnd = $random(seed);
            push_entry(int'(rnd[7:0]), int'(rnd[15:8]), rnd[19:16] != 4'd0);
        end
        flush_and_read();
    endtask

    task automatic check_result(input logic [7:0] expected);
        assert (result_out === expected) else begin
            $display("Fail at %0t ns: result_out expected 8'h%02h actual 8'h%02h",
                     $time, expected, result_out);
            $display("Test FAILED");
            $fatal(1, "result_out mismatch");
        end
    endtask

    initial begin : watchdog
        int limit_ns;
        wait (table_ready);
        limit_ns = (stim.size() + reset_cycles + 50) * clk_period;
        #(limit_ns);
        $display("Timeout: the stimulus table did not finish within %0d ns", limit_ns);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset         = 1'b1;
        weights_in    = 8'h00;
        activation_in = 8'sh00;
        run           = 1'b1;
        build_table();
        fill_expected();
        table_ready = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_result(8'h00);
        // drive on the falling edge and check the byte one cycle later
        for (int i = 0; i < stim.size(); i++) begin
            weights_in    = stim[i].weights;
            activation_in = stim[i].activation;
            run           = stim[i].run;
            @(negedge clk);
            check_result(stim[i].expected);
        end
        $display("Test OK");
        $finish;
    end

endmodule

//--- vlog.f
common/ternary_pkg.sv
design/trit_unpacker.sv
design/operand_stage.sv
design/mac_array/mac_array.sv
design/mac_array/readout_queue.sv
design/ternary_mac_top.sv
verif/tb_ternary_mac.sv
